// File: Bender.yml
package:
  name: fetch_stage

sources:
  - files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_pc_unit.sv
      - rtl/instr_mem.sv
      - rtl/fetch_debug_port.sv
      - rtl/fetch_stage.sv
  - target: test
    files:
      - tests/fetch_stage_assert.sv
      - tests/fetch_stage_tb.sv

// File: filelist.f
rtl/fetch_pkg.sv
rtl/fetch_pc_unit.sv
rtl/instr_mem.sv
rtl/fetch_debug_port.sv
rtl/fetch_stage.sv
tests/fetch_stage_assert.sv
tests/fetch_stage_tb.sv

// File: rtl/fetch_debug_port.sv
`timescale 1ns/1ps

module fetch_debug_port #(
   parameter int ADDR_W = 6  // word address bits
) (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic                         i_cs,         // host owns the memory port
   input  logic                         i_dbg_valid,
   input  fetch_pkg::dbg_word_u         i_dbg_word,
   input  logic [fetch_pkg::DATA_W-1:0] i_pc,
   input  fetch_pkg::if_id_t            i_latch,
   output logic [ADDR_W-1:0]            o_mem_addr,
   output logic                         o_mem_we,
   output logic [fetch_pkg::DATA_W-1:0] o_mem_wdata,
   output logic [fetch_pkg::DATA_W-1:0] o_dbg_word,   // readback value
   output logic                         o_dbg_valid   // one cycle pulse
);
   import fetch_pkg::*;

   typedef enum logic {
      ST_CMD,   // words decode as commands
      ST_DATA   // next word is a program word
   } state_e;

   state_e            state_q;
   logic [ADDR_W-1:0] wr_ptr_q;
   logic              take_cmd;
   logic              take_data;
   logic              is_read;
   logic [DATA_W-1:0] rd_sel;
   logic [DATA_W-1:0] rsp_q;
   logic              rsp_vld_q;

   assign take_cmd  = i_dbg_valid && (state_q == ST_CMD);
   assign take_data = i_dbg_valid && (state_q == ST_DATA);

   // readback select, only the command view matters here
   always_comb begin
      is_read = 1'b1;
      rd_sel  = i_pc;
      case (i_dbg_word.cmd.op)
         DBG_READ_PC:     rd_sel = i_pc;
         DBG_READ_LAT_LO: rd_sel = i_latch.pc_plus4;
         DBG_READ_LAT_HI: rd_sel = i_latch.instr;
         default:         is_read = 1'b0;
      endcase
   end

   // command / data fsm and write pointer
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q  <= ST_CMD;
         wr_ptr_q <= '0;
      end else if (take_cmd) begin
         case (i_dbg_word.cmd.op)
            DBG_SET_ADDR: wr_ptr_q <= i_dbg_word.cmd.waddr[ADDR_W-1:0];
            DBG_WRITE:    state_q  <= ST_DATA;
            default:      state_q  <= ST_CMD;  // reads and unknown ops
         endcase
      end else if (take_data) begin
         state_q <= ST_CMD;  // one data word per WRITE
         if (i_cs) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at the top of memory
         end
      end
   end

   // response strobe
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rsp_vld_q <= 1'b0;
      end else begin
         rsp_vld_q <= take_cmd && is_read;
      end
   end

   // response payload, sampled on the command edge
   always_ff @(posedge i_clk) begin
      if (take_cmd && is_read) begin
         rsp_q <= rd_sel;
      end
   end

   // data view of the same word goes straight to memory
   assign o_mem_addr  = wr_ptr_q;
   assign o_mem_we    = take_data && i_cs;
   assign o_mem_wdata = i_dbg_word.raw;

   assign o_dbg_word  = rsp_q;
   assign o_dbg_valid = rsp_vld_q;

endmodule

// File: rtl/fetch_pc_unit.sv
`timescale 1ns/1ps

module fetch_pc_unit (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic                         i_run,       // freeze when low
   input  logic                         i_pc_we,
   input  logic                         i_beq,
   input  logic                         i_jmp,
   input  logic                         i_if_id_we,
   input  logic [fetch_pkg::DATA_W-1:0] i_brq_addr,
   input  logic [fetch_pkg::DATA_W-1:0] i_jmp_addr,
   output logic [fetch_pkg::DATA_W-1:0] o_pc,
   output logic [fetch_pkg::DATA_W-1:0] o_pc_plus4  // IF/ID pc+4 field
);
   import fetch_pkg::*;

   logic [DATA_W-1:0] pc_q;
   logic [DATA_W-1:0] pc_plus4_q;
   logic [DATA_W-1:0] pc_inc;   // one adder for both registers
   logic [DATA_W-1:0] pc_next;

   assign pc_inc = pc_q + DATA_W'(4);

   // next pc select, branch and jump together means hold
   always_comb begin
      case ({i_pc_we, i_beq, i_jmp})
         3'b100:  pc_next = pc_inc;
         3'b110:  pc_next = i_brq_addr;
         3'b101:  pc_next = i_jmp_addr;
         default: pc_next = pc_q;
      endcase
   end

   // program counter
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc_q <= '0;
      end else if (i_run) begin
         pc_q <= pc_next;
      end
   end

   // pc+4 half of the IF/ID latch
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc_plus4_q <= '0;
      end else if (i_run && i_if_id_we) begin
         pc_plus4_q <= pc_inc;  // pairs with the instr read this edge
      end
   end

   assign o_pc       = pc_q;
   assign o_pc_plus4 = pc_plus4_q;

endmodule

// File: rtl/fetch_pkg.sv
package fetch_pkg;

   // word width shared by instructions, addresses and debug words
   localparam int DATA_W = 32;

   // sll $0,$0,0
   localparam logic [DATA_W-1:0] NOP_INSTR = '0;

   // host command opcodes, top nibble of a command word
   typedef enum logic [3:0] {
      DBG_NONE        = 4'h0,  // ignored
      DBG_SET_ADDR    = 4'h1,  // load write pointer
      DBG_WRITE       = 4'h2,  // next word is data
      DBG_READ_PC     = 4'h3,  // return pc
      DBG_READ_LAT_LO = 4'h4,  // return latched pc+4
      DBG_READ_LAT_HI = 4'h5   // return latched instr
   } dbg_op_e;

   // command view of a host word
   typedef struct packed {
      dbg_op_e     op;     // [31:28]
      logic [27:0] waddr;  // word address, only low bits used
   } dbg_cmd_t;

   // one host word, decoded as a command or taken as raw data
   // depending on the debug port state
   typedef union packed {
      dbg_cmd_t          cmd;
      logic [DATA_W-1:0] raw;
   } dbg_word_u;

   // IF/ID latch contents
   typedef struct packed {
      logic [DATA_W-1:0] pc_plus4;  // upper half
      logic [DATA_W-1:0] instr;     // lower half
   } if_id_t;

endpackage

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
   parameter int ADDR_W = 6  // instruction memory word address bits
) (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic                         i_run,       // debug enable, low freezes the stage
   input  logic                         i_pc_we,
   input  logic                         i_beq,
   input  logic                         i_jmp,
   input  logic                         i_if_id_we,
   input  logic                         i_flush,
   input  logic [fetch_pkg::DATA_W-1:0] i_brq_addr,
   input  logic [fetch_pkg::DATA_W-1:0] i_jmp_addr,
   input  logic                         i_dbg_cs,    // host owns memory address
   input  logic                         i_dbg_valid,
   input  fetch_pkg::dbg_word_u         i_dbg_word,
   output fetch_pkg::if_id_t            o_if_id,
   output logic [fetch_pkg::DATA_W-1:0] o_dbg_word,
   output logic                         o_dbg_valid
);
   import fetch_pkg::*;

   logic [DATA_W-1:0] pc;
   logic [DATA_W-1:0] pc_plus4;
   logic [DATA_W-1:0] instr;
   logic [DATA_W-1:0] mem_wdata;
   logic [ADDR_W-1:0] dbg_addr;
   logic [ADDR_W-1:0] mem_addr;
   logic              mem_we;
   logic              rd_en;
   if_id_t            latch;

   // debug pointer while selected, else pc word index
   assign mem_addr = i_dbg_cs ? dbg_addr : pc[ADDR_W+1:2];
   assign rd_en    = i_run && i_if_id_we;  // same qualifier as pc+4 reg

   assign latch.pc_plus4 = pc_plus4;
   assign latch.instr    = instr;
   assign o_if_id        = latch;

   fetch_pc_unit u_pc (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_run      (i_run),
      .i_pc_we    (i_pc_we),
      .i_beq      (i_beq),
      .i_jmp      (i_jmp),
      .i_if_id_we (i_if_id_we),
      .i_brq_addr (i_brq_addr),
      .i_jmp_addr (i_jmp_addr),
      .o_pc       (pc),
      .o_pc_plus4 (pc_plus4)
   );

   instr_mem #(.ADDR_W(ADDR_W)) u_imem (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_addr  (mem_addr),
      .i_we    (mem_we),     // already qualified by cs in the debug port
      .i_wdata (mem_wdata),
      .i_rd_en (rd_en),
      .i_flush (i_flush),
      .o_instr (instr)
   );

   fetch_debug_port #(.ADDR_W(ADDR_W)) u_dbg (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_cs        (i_dbg_cs),
      .i_dbg_valid (i_dbg_valid),
      .i_dbg_word  (i_dbg_word),
      .i_pc        (pc),
      .i_latch     (latch),
      .o_mem_addr  (dbg_addr),
      .o_mem_we    (mem_we),
      .o_mem_wdata (mem_wdata),
      .o_dbg_word  (o_dbg_word),
      .o_dbg_valid (o_dbg_valid)
   );

endmodule

// File: rtl/instr_mem.sv
`timescale 1ns/1ps

module instr_mem #(
   parameter int ADDR_W = 6  // word address bits
) (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic [ADDR_W-1:0]            i_addr,
   input  logic                         i_we,     // debug write
   input  logic [fetch_pkg::DATA_W-1:0] i_wdata,
   input  logic                         i_rd_en,  // latch enable for output reg
   input  logic                         i_flush,  // load nop instead of mem word
   output logic [fetch_pkg::DATA_W-1:0] o_instr
);
   import fetch_pkg::*;

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [0:DEPTH-1];
   logic [DATA_W-1:0] instr_q;  // IF/ID instr field

   // write port, lands on the presenting edge
   always_ff @(posedge i_clk) begin
      if (i_we) begin
         mem[i_addr] <= i_wdata;
      end
   end

   // registered read
   // a read on a write edge returns the old word
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         instr_q <= '0;
      end else if (i_rd_en) begin
         if (i_flush) begin
            instr_q <= NOP_INSTR;  // bubble
         end else begin
            instr_q <= mem[i_addr];
         end
      end
   end

   assign o_instr = instr_q;

endmodule

// File: tests/fetch_stage_assert.sv
`timescale 1ns/1ps

module fetch_stage_assert (
   input logic                         i_clk,
   input logic                         i_rst,
   input logic                         i_run,
   input logic                         i_if_id_we,
   input logic                         i_flush,
   input logic                         i_dbg_valid,
   input logic                         i_dbg_rsp_valid,  // o_dbg_valid of the stage
   input logic [fetch_pkg::DATA_W-1:0] i_pc,
   input logic [fetch_pkg::DATA_W-1:0] i_pc_plus4,
   input fetch_pkg::if_id_t            i_if_id
);
   import fetch_pkg::*;

   // frozen stage keeps pc and latched pc+4
   a_pc_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      !i_run |=> $stable(i_pc))
      else $error("pc changed while run was low");

   a_pc4_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      !i_run |=> $stable(i_pc_plus4))
      else $error("latched pc+4 changed while run was low");

   // each response pulse needs its own host word one cycle earlier
   a_rsp_single: assert property (@(posedge i_clk) disable iff (i_rst)
      i_dbg_rsp_valid |-> $past(i_dbg_valid))
      else $error("debug response without a command the cycle before");

   a_flush_nop: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_run && i_if_id_we && i_flush) |=> (i_if_id.instr == NOP_INSTR))
      else $error("instruction after flush is not a nop");

endmodule

bind fetch_stage fetch_stage_assert u_assert (
   .i_clk           (i_clk),
   .i_rst           (i_rst),
   .i_run           (i_run),
   .i_if_id_we      (i_if_id_we),
   .i_flush         (i_flush),
   .i_dbg_valid     (i_dbg_valid),
   .i_dbg_rsp_valid (o_dbg_valid),
   .i_pc            (pc),        // pc unit output
   .i_pc_plus4      (pc_plus4),
   .i_if_id         (o_if_id)
);

// File: tests/fetch_stage_tb.sv
`timescale 1ns/1ps

module fetch_stage_tb;
   import fetch_pkg::*;

   localparam int ADDR_W     = 6;
   localparam int CLK_PERIOD = 20;
   localparam int N_PROG     = 16;  // program words loaded by the host

   // control vectors, {run, pc_we, beq, jmp, if_id_we, flush}
   localparam logic [5:0] IDLE   = 6'b000000;
   localparam logic [5:0] SEQ    = 6'b110010;
   localparam logic [5:0] BEQ    = 6'b111010;
   localparam logic [5:0] JMP    = 6'b110110;
   localparam logic [5:0] BOTH   = 6'b111110;  // branch and jump together
   localparam logic [5:0] STALL  = 6'b100000;
   localparam logic [5:0] FREEZE = 6'b010010;  // run low, enables still high
   localparam logic [5:0] FLUSH  = 6'b110011;

   // one table row, expected fields filled in by the reference model
   typedef struct packed {
      logic              run;
      logic              pc_we;
      logic              beq;
      logic              jmp;
      logic              if_id_we;
      logic              flush;
      logic [DATA_W-1:0] brq_addr;
      logic [DATA_W-1:0] jmp_addr;
      logic              dbg_cs;
      logic              dbg_valid;
      dbg_word_u         dbg_word;
      if_id_t            exp_if_id;
      logic              exp_dbg_valid;
      logic [DATA_W-1:0] exp_dbg_word;
   } step_t;

   logic              clk;
   logic              rst;
   logic              run;
   logic              pc_we;
   logic              beq;
   logic              jmp;
   logic              if_id_we;
   logic              flush;
   logic [DATA_W-1:0] brq_addr;
   logic [DATA_W-1:0] jmp_addr;
   logic              dbg_cs;
   logic              dbg_valid;
   dbg_word_u         dbg_word;
   if_id_t            o_if_id;
   logic [DATA_W-1:0] o_dbg_word;
   logic              o_dbg_valid;

   step_t steps[$];
   logic  table_ready = 1'b0;
   int    n_err = 0;

   // reference model state
   logic [DATA_W-1:0] mdl_mem [0:(1 << ADDR_W)-1];
   logic [DATA_W-1:0] mdl_pc;
   if_id_t            mdl_latch;
   logic              mdl_data_st;  // next host word is data
   logic [ADDR_W-1:0] mdl_ptr;

   fetch_stage #(.ADDR_W(ADDR_W)) fetch_stage_i (
      .i_clk       (clk),
      .i_rst       (rst),
      .i_run       (run),
      .i_pc_we     (pc_we),
      .i_beq       (beq),
      .i_jmp       (jmp),
      .i_if_id_we  (if_id_we),
      .i_flush     (flush),
      .i_brq_addr  (brq_addr),
      .i_jmp_addr  (jmp_addr),
      .i_dbg_cs    (dbg_cs),
      .i_dbg_valid (dbg_valid),
      .i_dbg_word  (dbg_word),
      .o_if_id     (o_if_id),
      .o_dbg_word  (o_dbg_word),
      .o_dbg_valid (o_dbg_valid)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic step_t ctrl_step(input logic [5:0] ctl, input logic [DATA_W-1:0] brq,
                                       input logic [DATA_W-1:0] jaddr);
      step_t s;
      s = '0;
      {s.run, s.pc_we, s.beq, s.jmp, s.if_id_we, s.flush} = ctl;
      s.brq_addr = brq;
      s.jmp_addr = jaddr;
      return s;
   endfunction

   function automatic step_t cmd_step(input logic [5:0] ctl, input logic cs, input dbg_op_e op,
                                      input logic [27:0] waddr);
      step_t s;
      s = ctrl_step(ctl, '0, '0);
      s.dbg_cs              = cs;
      s.dbg_valid           = 1'b1;
      s.dbg_word.cmd.op     = op;
      s.dbg_word.cmd.waddr  = waddr;
      return s;
   endfunction

   function automatic step_t data_step(input logic cs, input logic [DATA_W-1:0] raw);
      step_t s;
      s = ctrl_step(IDLE, '0, '0);
      s.dbg_cs       = cs;
      s.dbg_valid    = 1'b1;
      s.dbg_word.raw = raw;
      return s;
   endfunction

   // advance the model by one edge and store the row with its expectations
   task automatic add_step(input step_t s);
      step_t             e;
      logic [DATA_W-1:0] pc_inc;
      logic [DATA_W-1:0] rd_word;
      e       = s;
      pc_inc  = mdl_pc + 32'd4;
      rd_word = mdl_mem[s.dbg_cs ? mdl_ptr : mdl_pc[ADDR_W+1:2]];  // word before any write
      e.exp_dbg_valid = 1'b0;
      e.exp_dbg_word  = '0;
      if (s.dbg_valid && mdl_data_st) begin
         if (s.dbg_cs) begin
            mdl_mem[mdl_ptr] = s.dbg_word.raw;
            mdl_ptr          = mdl_ptr + 1'b1;
         end
         mdl_data_st = 1'b0;
      end else if (s.dbg_valid) begin
         case (s.dbg_word.cmd.op)
            DBG_SET_ADDR:    mdl_ptr = s.dbg_word.cmd.waddr[ADDR_W-1:0];
            DBG_WRITE:       mdl_data_st = 1'b1;
            DBG_READ_PC: begin
               e.exp_dbg_valid = 1'b1;
               e.exp_dbg_word  = mdl_pc;
            end
            DBG_READ_LAT_LO: begin
               e.exp_dbg_valid = 1'b1;
               e.exp_dbg_word  = mdl_latch.pc_plus4;
            end
            DBG_READ_LAT_HI: begin
               e.exp_dbg_valid = 1'b1;
               e.exp_dbg_word  = mdl_latch.instr;
            end
            default:         ;  // only reads answer
         endcase
      end
      if (s.run && s.if_id_we) begin
         mdl_latch.pc_plus4 = pc_inc;
         mdl_latch.instr    = s.flush ? NOP_INSTR : rd_word;
      end
      if (s.run && s.pc_we && !(s.beq && s.jmp)) begin
         mdl_pc = s.beq ? s.brq_addr : (s.jmp ? s.jmp_addr : pc_inc);
      end
      e.exp_if_id = mdl_latch;
      steps.push_back(e);
   endtask

   task automatic build_table();
      int i;
      mdl_pc      = '0;
      mdl_latch   = '0;
      mdl_data_st = 1'b0;
      mdl_ptr     = '0;
      // program load with the stage idle
      add_step(cmd_step(IDLE, 1'b1, DBG_SET_ADDR, 28'd0));
      for (i = 0; i < N_PROG; i++) begin
         add_step(cmd_step(IDLE, 1'b1, DBG_WRITE, 28'd0));
         add_step(data_step(1'b1, $urandom()));
      end
      // host word with cs low must not reach memory
      add_step(cmd_step(IDLE, 1'b0, DBG_SET_ADDR, 28'd2));
      add_step(cmd_step(IDLE, 1'b0, DBG_WRITE, 28'd0));
      add_step(data_step(1'b0, ~mdl_mem[2]));
      for (i = 0; i < 12; i++) begin
         add_step(ctrl_step(SEQ, 32'h0, 32'h0));  // words 0..11
      end
      add_step(ctrl_step(BEQ, 32'h10, 32'h2c));   // fetch 12, branch to word 4
      add_step(ctrl_step(SEQ, 32'h0, 32'h0));
      add_step(ctrl_step(JMP, 32'h08, 32'h34));   // fetch 5, jump to word 13
      add_step(ctrl_step(SEQ, 32'h0, 32'h0));
      add_step(ctrl_step(SEQ, 32'h0, 32'h0));
      add_step(ctrl_step(BOTH, 32'h00, 32'h04));  // pc holds at 0x3c
      add_step(ctrl_step(BEQ, 32'h00, 32'h18));   // back to 0
      add_step(ctrl_step(STALL, 32'h0, 32'h0));
      add_step(ctrl_step(STALL, 32'h0, 32'h0));
      add_step(cmd_step(STALL, 1'b0, DBG_READ_PC, 28'd0));
      add_step(ctrl_step(FREEZE, 32'h0, 32'h0));
      add_step(ctrl_step(FREEZE, 32'h0, 32'h0));
      add_step(cmd_step(FREEZE, 1'b0, DBG_READ_PC, 28'd0));
      add_step(cmd_step(FREEZE, 1'b0, DBG_READ_LAT_LO, 28'd0));
      add_step(cmd_step(FREEZE, 1'b0, DBG_READ_LAT_HI, 28'd0));
      add_step(ctrl_step(FLUSH, 32'h0, 32'h0));
      add_step(ctrl_step(FLUSH, 32'h0, 32'h0));
      add_step(ctrl_step(SEQ, 32'h0, 32'h0));
      // back to back readback while fetching
      add_step(cmd_step(SEQ, 1'b0, DBG_READ_PC, 28'd0));
      add_step(cmd_step(SEQ, 1'b0, DBG_READ_LAT_LO, 28'd0));
      add_step(cmd_step(SEQ, 1'b0, DBG_READ_LAT_HI, 28'd0));
      add_step(ctrl_step(IDLE, 32'h0, 32'h0));
   endtask

   task automatic drive_step(input step_t s);
      run       = s.run;
      pc_we     = s.pc_we;
      beq       = s.beq;
      jmp       = s.jmp;
      if_id_we  = s.if_id_we;
      flush     = s.flush;
      brq_addr  = s.brq_addr;
      jmp_addr  = s.jmp_addr;
      dbg_cs    = s.dbg_cs;
      dbg_valid = s.dbg_valid;
      dbg_word  = s.dbg_word;
   endtask

   task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
      if (got !== exp) begin
         n_err++;
         $display("Mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
         $display(">>> FAIL");
         $fatal(1, "stopping at first error");
      end
   endtask

   initial begin
      int i;
      void'($urandom(32'h48d03144));
      rst = 1'b1;
      drive_step('0);
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0;
      compare_value(o_if_id, '0, "o_if_id after reset");
      compare_value(o_dbg_valid, 1'b0, "o_dbg_valid after reset");
      for (i = 0; i < steps.size(); i++) begin
         drive_step(steps[i]);
         @(posedge clk);
         #2;  // outputs settled after the edge
         compare_value(o_if_id, steps[i].exp_if_id, $sformatf("step %0d o_if_id", i));
         compare_value(o_dbg_valid, steps[i].exp_dbg_valid,
                       $sformatf("step %0d o_dbg_valid", i));
         if (steps[i].exp_dbg_valid) begin
            compare_value(o_dbg_word, steps[i].exp_dbg_word,
                          $sformatf("step %0d o_dbg_word", i));
         end
      end
      if (n_err == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // watchdog, table length plus reset and margin
   initial begin
      wait (table_ready);
      #((steps.size() + 50) * CLK_PERIOD);
      $display("Timeout: the stimulus table did not finish in the expected time");
      $display(">>> FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule
